// ==== hdl/fdc_bus_pkg.sv ====
package fdc_bus_pkg;

	////////////////////////////////////////////////////////////
	// Local bus geometry
	////////////////////////////////////////////////////////////

	// Processor address and data widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Zero page covers 0x0000..0x01FF
	localparam int ZP_DEPTH = 512;

	// Host register mailbox at the top of the zero page
	localparam logic [ADDR_W-1:0] MAILBOX_BASE = 16'h01F8;

	// I/O ports live in page 0xE0
	localparam logic [7:0] IO_PAGE = 8'hE0;

	// Page and offset view of a local address
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} fdc_page_off_t;

	// Raw view for range checks, page view for I/O decode
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		fdc_page_off_t     po;
	} fdc_addr_u;

endpackage

// ==== hdl/fdc_io_pkg.sv ====
package fdc_io_pkg;

	////////////////////////////////////////////////////////////
	// I/O page offsets
	////////////////////////////////////////////////////////////

	// SD card chip select
	localparam logic [7:0] PORT_MMCA = 8'd0;
	// SPI data and status
	localparam logic [7:0] PORT_SPDR = 8'd1;
	localparam logic [7:0] PORT_SPSR = 8'd2;
	// UART transmit data and control/status
	localparam logic [7:0] PORT_TXD  = 8'd4;
	localparam logic [7:0] PORT_CTL  = 8'd6;
	// Two tick-driven down counters
	localparam logic [7:0] PORT_TMR1 = 8'd7;
	localparam logic [7:0] PORT_TMR2 = 8'd8;
	// Debug LED latch
	localparam logic [7:0] PORT_LED  = 8'd16;

	////////////////////////////////////////////////////////////
	// Status and mailbox
	////////////////////////////////////////////////////////////

	// Busy or ready flag position in SPSR and CTL
	localparam int ST_BUSY_BIT = 0;

	// Data, sector, track, command, control
	localparam int HOST_REGS = 5;

	// Value returned by reads of unmapped locations
	localparam logic [7:0] RD_UNMAPPED = 8'hFF;

endpackage

// ==== hdl/fdc_bus_if.sv ====
`timescale 1ns/100ps

interface fdc_bus_if;

	// Address with raw and page/offset views
	fdc_bus_pkg::fdc_addr_u addr;

	// Write data and strobe
	logic [fdc_bus_pkg::DATA_W-1:0] wdata;
	logic wr;

	// Slave select, one per interface instance
	logic sel;

	// Registered read data, valid the cycle after sel
	logic [fdc_bus_pkg::DATA_W-1:0] rdata;

	// Arbiter side
	modport master (
		output addr, wdata, wr, sel,
		input  rdata
	);

	// Zero page and I/O block side
	modport slave (
		input  addr, wdata, wr, sel,
		output rdata
	);

endinterface

// ==== hdl/fdc_uart_tx.sv ====
`timescale 1ns/100ps

module fdc_uart_tx #(
	parameter int BAUD_DIV = 868
) (
	input  logic clk,
	input  logic reset_n,
	input  logic load,
	input  logic [7:0] data,
	output logic txd,
	output logic busy
);
	localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

	logic [BW-1:0] baud_cnt;
	logic bit_end;
	// Ten bits per frame
	logic [3:0] bit_cnt;
	// Stop, data LSB first, start
	logic [9:0] frame;

	assign bit_end = (baud_cnt == BW'(BAUD_DIV - 1));
	// Idle line shifts in ones
	assign txd = frame[0];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= 4'd0;
			frame <= '1;
		end else if (load && !busy) begin
			// Start bit on the line next cycle
			frame <= {1'b1, data, 1'b0};
			busy <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= 4'd0;
		end else if (busy) begin
			if (bit_end) begin
				baud_cnt <= '0;
				frame <= {1'b1, frame[9:1]};
				// Busy falls after the stop bit
				if (bit_cnt == 4'd9)
					busy <= 1'b0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/fdc_spi_master.sv ====
`timescale 1ns/100ps

module fdc_spi_master #(
	parameter int SPI_DIV = 4
) (
	input  logic clk,
	input  logic reset_n,
	input  logic wr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic ready,
	output logic sck,
	output logic mosi,
	input  logic miso
);
	localparam int DW = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;

	logic [DW-1:0] div_cnt;
	logic half_end;
	// Counts falling edges
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic miso_q;
	logic start;

	assign start = wr && ready;
	assign half_end = (div_cnt == DW'(SPI_DIV - 1));

	// Out from the top, in at the bottom
	assign mosi = shreg[7];
	assign rdata = shreg;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ready <= 1'b1;
			sck <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= 3'd0;
		end else if (start) begin
			ready <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= 3'd0;
		end else if (!ready) begin
			if (half_end) begin
				div_cnt <= '0;
				sck <= !sck;
				// Eighth falling edge ends the byte
				if (sck) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						ready <= 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Mode 0, sample on rise and shift on fall
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			shreg <= 8'hFF;
		end else if (start) begin
			shreg <= wdata;
		end else if (!ready && half_end && sck) begin
			shreg <= {shreg[6:0], miso_q};
		end
	end

	always_ff @(posedge clk) begin
		if (!ready && half_end && !sck)
			miso_q <= miso;
	end

endmodule

// ==== hdl/fdc_zero_page.sv ====
`timescale 1ns/100ps

module fdc_zero_page (
	input logic clk,
	fdc_bus_if.slave bus
);
	localparam int ZW = $clog2(fdc_bus_pkg::ZP_DEPTH);

	// 512 bytes, mailbox in the top eight
	logic [fdc_bus_pkg::DATA_W-1:0] mem [fdc_bus_pkg::ZP_DEPTH];
	logic [ZW-1:0] idx;

	// Low address bits only, arbiter did the range check
	assign idx = bus.addr.raw[ZW-1:0];

	always_ff @(posedge clk) begin
		if (bus.sel) begin
			if (bus.wr)
				mem[idx] <= bus.wdata;
			// Old contents on a write cycle
			bus.rdata <= mem[idx];
		end
	end

endmodule

// ==== hdl/fdc_io_ports.sv ====
`timescale 1ns/100ps

module fdc_io_ports #(
	parameter int TICK_DIV = 500000,
	parameter int SPI_DIV = 4,
	parameter int BAUD_DIV = 868
) (
	input  logic clk,
	input  logic reset_n,
	fdc_bus_if.slave bus,
	output logic [7:0] leds,
	output logic sd_cs,
	output logic sd_clk,
	output logic sd_mosi,
	input  logic sd_miso,
	output logic uart_txd
);
	localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [7:0] off;
	logic wr_en;
	logic spi_wr;
	logic [7:0] spi_rdata;
	logic spi_ready;
	logic uart_load;
	logic uart_busy;
	logic [7:0] spsr;
	logic [7:0] ctl;

	// Timer tick prescaler
	logic [TW-1:0] tick_cnt;
	logic tick;
	logic [1:0] tmr_load;
	logic [7:0] tmr [2];

	assign off = bus.addr.po.offset;
	assign wr_en = bus.sel && bus.wr;

	// Load strobes
	assign spi_wr = wr_en && (off == fdc_io_pkg::PORT_SPDR);
	// Writes during a frame are dropped
	assign uart_load = wr_en && (off == fdc_io_pkg::PORT_TXD) && !uart_busy;
	assign tmr_load[0] = wr_en && (off == fdc_io_pkg::PORT_TMR1);
	assign tmr_load[1] = wr_en && (off == fdc_io_pkg::PORT_TMR2);

	////////////////////////////////////////////////////////////
	// Latches and timers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			leds <= 8'h00;
			sd_cs <= 1'b1;
		end else begin
			if (wr_en && (off == fdc_io_pkg::PORT_LED))
				leds <= bus.wdata;
			// Chip select from bit 0
			if (wr_en && (off == fdc_io_pkg::PORT_MMCA))
				sd_cs <= bus.wdata[0];
		end
	end

	assign tick = (tick_cnt == TW'(TICK_DIV - 1));

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			tick_cnt <= '0;
			tmr[0] <= 8'h00;
			tmr[1] <= 8'h00;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			for (int i = 0; i < 2; i++) begin
				// Load wins over a tick, count stops at zero
				if (tmr_load[i])
					tmr[i] <= bus.wdata;
				else if (tick && (tmr[i] != 8'h00))
					tmr[i] <= tmr[i] - 8'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Status and read mux
	////////////////////////////////////////////////////////////

	always_comb begin
		spsr = 8'h00;
		ctl = 8'h00;
		spsr[fdc_io_pkg::ST_BUSY_BIT] = spi_ready;
		ctl[fdc_io_pkg::ST_BUSY_BIT] = uart_busy;
	end

	always_ff @(posedge clk) begin
		if (bus.sel) begin
			case (off)
				fdc_io_pkg::PORT_SPDR: bus.rdata <= spi_rdata;
				fdc_io_pkg::PORT_SPSR: bus.rdata <= spsr;
				fdc_io_pkg::PORT_CTL:  bus.rdata <= ctl;
				fdc_io_pkg::PORT_TMR1: bus.rdata <= tmr[0];
				fdc_io_pkg::PORT_TMR2: bus.rdata <= tmr[1];
				default:               bus.rdata <= fdc_io_pkg::RD_UNMAPPED;
			endcase
		end
	end

	// SD card link
	fdc_spi_master #(.SPI_DIV(SPI_DIV)) u_spi (
		.clk(clk),
		.reset_n(reset_n),
		.wr(spi_wr),
		.wdata(bus.wdata),
		.rdata(spi_rdata),
		.ready(spi_ready),
		.sck(sd_clk),
		.mosi(sd_mosi),
		.miso(sd_miso)
	);

	// Debug serial output
	fdc_uart_tx #(.BAUD_DIV(BAUD_DIV)) u_uart (
		.clk(clk),
		.reset_n(reset_n),
		.load(uart_load),
		.data(bus.wdata),
		.txd(uart_txd),
		.busy(uart_busy)
	);

endmodule

// ==== hdl/fdc_bus_arbiter.sv ====
`timescale 1ns/100ps

module fdc_bus_arbiter (
	input  logic clk,
	input  logic reset_n,
	input  logic [fdc_bus_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [fdc_bus_pkg::DATA_W-1:0] cpu_wdata,
	input  logic cpu_wr,
	input  logic cpu_ce,
	output logic [fdc_bus_pkg::DATA_W-1:0] cpu_rdata,
	input  logic [$clog2(fdc_io_pkg::HOST_REGS)-1:0] hostio_addr,
	input  logic [fdc_bus_pkg::DATA_W-1:0] hostio_idata,
	input  logic hostio_rd,
	input  logic hostio_wr,
	output logic [fdc_bus_pkg::DATA_W-1:0] hostio_odata,
	output logic host_done,
	fdc_bus_if.master zp_bus,
	fdc_bus_if.master io_bus
);
	localparam int HW = $clog2(fdc_io_pkg::HOST_REGS);
	localparam int AW = fdc_bus_pkg::ADDR_W;

	// Pending host request and its payload
	logic host_pend;
	logic host_is_rd;
	logic [HW-1:0] host_idx;
	logic [fdc_bus_pkg::DATA_W-1:0] host_data;
	logic host_req;

	// Current bus cycle
	logic host_grant;
	logic any_grant;
	fdc_bus_pkg::fdc_addr_u bus_addr;
	logic [fdc_bus_pkg::DATA_W-1:0] bus_wdata;
	logic bus_wr;
	logic zp_hit;
	logic io_hit;

	// Where the read data of this cycle comes from
	logic rd_zp_q;
	logic rd_io_q;
	logic rd_host_q;
	logic [fdc_bus_pkg::DATA_W-1:0] rd_data;

	// New strobes count only when nothing is pending
	assign host_req = !host_pend && (hostio_wr || hostio_rd);
	// Processor always wins
	assign host_grant = host_pend && !cpu_ce;
	assign any_grant = cpu_ce || host_pend;
	assign host_done = host_grant;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			host_pend <= 1'b0;
		end else if (host_grant) begin
			host_pend <= 1'b0;
		end else if (host_req) begin
			host_pend <= 1'b1;
		end
	end

	// Write beats read if both strobes come together
	always_ff @(posedge clk) begin
		if (host_req) begin
			host_is_rd <= !hostio_wr;
			host_idx <= hostio_addr;
			host_data <= hostio_idata;
		end
	end

	////////////////////////////////////////////////////////////
	// Peer mux and slave decode
	////////////////////////////////////////////////////////////

	always_comb begin
		if (cpu_ce) begin
			bus_addr.raw = cpu_addr;
			bus_wdata = cpu_wdata;
			bus_wr = cpu_wr;
		end else begin
			// Host register index lands in the mailbox
			bus_addr.raw = fdc_bus_pkg::MAILBOX_BASE + {{(AW-HW){1'b0}}, host_idx};
			bus_wdata = host_data;
			bus_wr = !host_is_rd;
		end
		zp_hit = any_grant && (bus_addr.raw < fdc_bus_pkg::ZP_DEPTH);
		io_hit = any_grant && (bus_addr.po.page == fdc_bus_pkg::IO_PAGE);
	end

	assign zp_bus.addr = bus_addr;
	assign zp_bus.wdata = bus_wdata;
	assign zp_bus.wr = bus_wr;
	assign zp_bus.sel = zp_hit;

	assign io_bus.addr = bus_addr;
	assign io_bus.wdata = bus_wdata;
	assign io_bus.wr = bus_wr;
	assign io_bus.sel = io_hit;

	////////////////////////////////////////////////////////////
	// Read return
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_zp_q <= 1'b0;
			rd_io_q <= 1'b0;
			rd_host_q <= 1'b0;
		end else begin
			rd_zp_q <= zp_hit && !bus_wr;
			rd_io_q <= io_hit && !bus_wr;
			rd_host_q <= host_grant && host_is_rd;
		end
	end

	// Slaves already register their data
	always_comb begin
		if (rd_zp_q)
			rd_data = zp_bus.rdata;
		else if (rd_io_q)
			rd_data = io_bus.rdata;
		else
			rd_data = fdc_io_pkg::RD_UNMAPPED;
	end

	assign cpu_rdata = rd_data;

	// Host copy holds until the next host read
	always_ff @(posedge clk) begin
		if (rd_host_q)
			hostio_odata <= rd_data;
	end

endmodule

// ==== hdl/fdc_subsystem.sv ====
`timescale 1ns/100ps

module fdc_subsystem #(
	parameter int SPI_DIV = 4,
	parameter int BAUD_DIV = 868,
	parameter int TICK_DIV = 500000
) (
	input  logic clk,
	input  logic reset_n,
	// Processor port
	input  logic [fdc_bus_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [fdc_bus_pkg::DATA_W-1:0] cpu_wdata,
	input  logic cpu_ce,
	input  logic cpu_wr,
	output logic [fdc_bus_pkg::DATA_W-1:0] cpu_rdata,
	// Host register window
	input  logic [$clog2(fdc_io_pkg::HOST_REGS)-1:0] hostio_addr,
	input  logic [fdc_bus_pkg::DATA_W-1:0] hostio_idata,
	input  logic hostio_rd,
	input  logic hostio_wr,
	output logic [fdc_bus_pkg::DATA_W-1:0] hostio_odata,
	output logic host_done,
	// Peripherals
	output logic [7:0] leds,
	output logic sd_cs,
	output logic sd_clk,
	output logic sd_mosi,
	input  logic sd_miso,
	output logic uart_txd
);

	// One local bus per slave
	fdc_bus_if zp_bus ();
	fdc_bus_if io_bus ();

	fdc_bus_arbiter u_arb (
		.clk(clk),
		.reset_n(reset_n),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_wr(cpu_wr),
		.cpu_ce(cpu_ce),
		.cpu_rdata(cpu_rdata),
		.hostio_addr(hostio_addr),
		.hostio_idata(hostio_idata),
		.hostio_rd(hostio_rd),
		.hostio_wr(hostio_wr),
		.hostio_odata(hostio_odata),
		.host_done(host_done),
		.zp_bus(zp_bus.master),
		.io_bus(io_bus.master)
	);

	fdc_zero_page u_zp (
		.clk(clk),
		.bus(zp_bus.slave)
	);

	fdc_io_ports #(
		.TICK_DIV(TICK_DIV),
		.SPI_DIV(SPI_DIV),
		.BAUD_DIV(BAUD_DIV)
	) u_io (
		.clk(clk),
		.reset_n(reset_n),
		.bus(io_bus.slave),
		.leds(leds),
		.sd_cs(sd_cs),
		.sd_clk(sd_clk),
		.sd_mosi(sd_mosi),
		.sd_miso(sd_miso),
		.uart_txd(uart_txd)
	);

endmodule

// ==== verif/fdc_props.sv ====
`timescale 1ns/100ps

module fdc_arb_props (
	input logic clk,
	input logic reset_n,
	input logic cpu_ce,
	input logic host_done,
	input logic zp_sel,
	input logic io_sel,
	input logic [fdc_bus_pkg::ADDR_W-1:0] zp_addr
);

	// First address past the host registers
	localparam logic [fdc_bus_pkg::ADDR_W-1:0] MBOX_END =
		fdc_bus_pkg::MAILBOX_BASE + 16'(fdc_io_pkg::HOST_REGS);

	// One slave per bus cycle
	a_one_sel: assert property (@(posedge clk) disable iff (!reset_n) !(zp_sel && io_sel))
		else $error("zero page and I/O selected in the same cycle");

	// Host only completes on a free bus, on its own mailbox cycle
	a_done_idle: assert property (@(posedge clk) disable iff (!reset_n)
		host_done |-> !cpu_ce && zp_sel && (zp_addr >= fdc_bus_pkg::MAILBOX_BASE)
			&& (zp_addr < MBOX_END))
		else $error("host_done outside a free mailbox cycle");

	// Nothing pending right out of reset
	a_done_reset: assert property (@(posedge clk) $rose(reset_n) |-> !host_done)
		else $error("host_done high on the first cycle after reset");

endmodule

bind fdc_bus_arbiter fdc_arb_props u_props (
	.clk(clk),
	.reset_n(reset_n),
	.cpu_ce(cpu_ce),
	.host_done(host_done),
	.zp_sel(zp_hit),
	.io_sel(io_hit),
	.zp_addr(bus_addr.raw)
);

// ==== verif/fdc_tb.sv ====
`timescale 1ns/100ps

module fdc_tb;

	localparam int SPI_DIV = 2;
	localparam int BAUD_DIV = 4;
	localparam int TICK_DIV = 8;
	localparam int HW = $clog2(fdc_io_pkg::HOST_REGS);
	// Poll limit for every wait loop
	localparam int POLL_MAX = 400;

	typedef logic [fdc_bus_pkg::DATA_W-1:0] byte_t;
	typedef logic [fdc_bus_pkg::ADDR_W-1:0] addr_t;

	logic clk;
	logic reset_n;
	addr_t cpu_addr;
	byte_t cpu_wdata;
	logic cpu_ce;
	logic cpu_wr;
	byte_t cpu_rdata;
	logic [HW-1:0] hostio_addr;
	byte_t hostio_idata;
	logic hostio_rd;
	logic hostio_wr;
	byte_t hostio_odata;
	logic host_done;
	logic [7:0] leds;
	logic sd_cs;
	logic sd_clk;
	logic sd_mosi;
	logic sd_miso = 1'b1;
	logic uart_txd;

	// Scoreboard
	byte_t shadow [fdc_bus_pkg::ZP_DEPTH];
	bit zp_valid [fdc_bus_pkg::ZP_DEPTH];
	byte_t spdr_exp = 8'hFF;
	int want_q [$];
	int val_errs = 0;
	int other_errs = 0;
	int done_cnt = 0;
	int host_ops = 0;
	logic [31:0] rnd_state = 32'h85b6b295;

	// SD card slave model
	byte_t spi_tx = 8'hFF;
	byte_t spi_rx = 8'h00;
	logic spi_arm = 1'b0;
	logic sck_prev = 1'b0;
	int miso_bit = -1;
	int spi_bits = 0;

	// Serial line model
	byte_t uart_rx = 8'h00;
	int uart_frames = 0;

	fdc_subsystem #(
		.SPI_DIV(SPI_DIV),
		.BAUD_DIV(BAUD_DIV),
		.TICK_DIV(TICK_DIV)
	) uut (
		.clk(clk),
		.reset_n(reset_n),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ce(cpu_ce),
		.cpu_wr(cpu_wr),
		.cpu_rdata(cpu_rdata),
		.hostio_addr(hostio_addr),
		.hostio_idata(hostio_idata),
		.hostio_rd(hostio_rd),
		.hostio_wr(hostio_wr),
		.hostio_odata(hostio_odata),
		.host_done(host_done),
		.leds(leds),
		.sd_cs(sd_cs),
		.sd_clk(sd_clk),
		.sd_mosi(sd_mosi),
		.sd_miso(sd_miso),
		.uart_txd(uart_txd)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift(rnd_state);
		return rnd_state;
	endfunction

	function automatic addr_t io_addr(input logic [7:0] off);
		return {8'hE0, off};
	endfunction

	// Host register i sits at 0x1F8 + i
	function automatic addr_t mbox_addr(input int idx);
		return 16'h01F8 + 16'(idx);
	endfunction

	// Expected read byte, -1 where the value moves on its own
	function automatic int fdc_expect(input addr_t a);
		if (a < 16'h0200)
			return int'(shadow[a[8:0]]);
		if (a[15:8] != 8'hE0)
			return 255;
		case (a[7:0])
			8'd1: return int'(spdr_exp);
			// SPSR, CTL and both timers
			8'd2, 8'd6, 8'd7, 8'd8: return -1;
			default: return 255;
		endcase
	endfunction

	task automatic check_byte(input string name, input byte_t got, input byte_t want);
		if (got !== want) begin
			val_errs++;
			$display("** Error: %s = 0x%02h, expected 0x%02h at %0t", name, got, want, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			val_errs++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	task automatic fail_note(input string what);
		other_errs++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////
	// Bus tasks, entered just after a falling edge
	////////////////////////////////////////////////////////////

	task automatic cpu_write(input addr_t a, input byte_t d);
		cpu_addr = a;
		cpu_wdata = d;
		cpu_wr = 1'b1;
		cpu_ce = 1'b1;
		if (a < 16'h0200) begin
			shadow[a[8:0]] = d;
			zp_valid[a[8:0]] = 1'b1;
		end
		@(negedge clk);
		cpu_ce = 1'b0;
		cpu_wr = 1'b0;
	endtask

	// Result valid one cycle after the granted cycle
	task automatic cpu_read(input addr_t a, output byte_t d);
		want_q.push_back(fdc_expect(a));
		cpu_addr = a;
		cpu_wr = 1'b0;
		cpu_ce = 1'b1;
		@(negedge clk);
		d = cpu_rdata;
		cpu_ce = 1'b0;
	endtask

	// One random zero-page access outside the mailbox
	task automatic zp_traffic();
		logic [31:0] r;
		addr_t a;
		byte_t got;
		r = next_rand();
		a = {7'd0, r[8:0]};
		if (a >= 16'h01F8)
			a = a - 16'h0100;
		if (r[31] && zp_valid[a[8:0]])
			cpu_read(a, got);
		else
			cpu_write(a, r[23:16]);
	endtask

	task automatic wait_done(input int target);
		int n;
		n = 0;
		while (done_cnt < target && n < POLL_MAX) begin
			@(negedge clk);
			n++;
		end
		if (done_cnt < target)
			fail_note("timeout waiting for host_done");
	endtask

	task automatic host_write(input int idx, input byte_t d);
		hostio_addr = HW'(idx);
		hostio_idata = d;
		hostio_wr = 1'b1;
		shadow[mbox_addr(idx) & 16'h01FF] = d;
		zp_valid[mbox_addr(idx) & 16'h01FF] = 1'b1;
		host_ops++;
		@(negedge clk);
		hostio_wr = 1'b0;
	endtask

	task automatic host_read(input int idx, output byte_t d);
		hostio_addr = HW'(idx);
		hostio_rd = 1'b1;
		host_ops++;
		@(negedge clk);
		hostio_rd = 1'b0;
		wait_done(host_ops);
		// Output register loads one cycle after the grant
		@(negedge clk);
		d = hostio_odata;
	endtask

	task automatic timer_run(input logic [7:0] off, input byte_t start);
		byte_t prev;
		byte_t got;
		int n;
		cpu_write(io_addr(off), start);
		prev = start;
		got = start;
		n = 0;
		while (got != 8'h00 && n < POLL_MAX) begin
			cpu_read(io_addr(off), got);
			if (got > prev)
				fail_note("timer count went up");
			prev = got;
			n++;
		end
		if (got != 8'h00)
			fail_note("timeout waiting for timer to reach zero");
		// Stays at zero
		repeat (2 * TICK_DIV) @(negedge clk);
		cpu_read(io_addr(off), got);
		check_byte("timer", got, 8'h00);
	endtask

	////////////////////////////////////////////////////////////
	// Monitors and line models
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset_n && host_done)
			done_cnt++;
	end

	// Checks cpu_rdata one cycle after each processor read
	initial begin : compare_reads
		int want;
		forever begin
			@(posedge clk);
			if (reset_n && cpu_ce && !cpu_wr) begin
				if (want_q.size() == 0) begin
					fail_note("processor read with no expected value queued");
					want = -1;
				end else begin
					want = want_q.pop_front();
				end
				@(negedge clk);
				if (want >= 0)
					check_byte("cpu_rdata", cpu_rdata, byte_t'(want));
			end
		end
	end

	// Mode-0 slave, edges of sd_clk seen on the falling clock
	always @(negedge clk) begin
		if (spi_arm) begin
			sd_miso = spi_tx[7];
			miso_bit = 6;
			spi_bits = 0;
			spi_arm = 1'b0;
		end else if (reset_n) begin
			if (sd_clk && !sck_prev) begin
				spi_rx = {spi_rx[6:0], sd_mosi};
				spi_bits++;
			end
			// Next bit after each falling sck
			if (!sd_clk && sck_prev && miso_bit >= 0) begin
				sd_miso = spi_tx[miso_bit];
				miso_bit--;
			end
		end
		sck_prev = sd_clk;
	end

	// 8N1 receiver, mid-bit sampling
	initial begin : uart_line
		byte_t rx;
		forever begin
			@(negedge clk);
			if (reset_n && uart_txd === 1'b0) begin
				repeat (BAUD_DIV / 2) @(negedge clk);
				if (uart_txd !== 1'b0)
					fail_note("UART start bit too short");
				for (int i = 0; i < 8; i++) begin
					repeat (BAUD_DIV) @(negedge clk);
					rx[i] = uart_txd;
				end
				repeat (BAUD_DIV) @(negedge clk);
				if (uart_txd !== 1'b1)
					fail_note("UART stop bit missing");
				uart_rx = rx;
				uart_frames++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] r;
		byte_t d;
		byte_t got;
		int n;
		int frames;
		reset_n = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_ce = 1'b0;
		cpu_wr = 1'b0;
		hostio_addr = '0;
		hostio_idata = '0;
		hostio_rd = 1'b0;
		hostio_wr = 1'b0;
		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);

		// Idle levels out of reset
		check_bit("sd_cs", sd_cs, 1'b1);
		check_bit("sd_clk", sd_clk, 1'b0);
		check_bit("uart_txd", uart_txd, 1'b1);
		check_byte("leds", leds, 8'h00);
		check_bit("host_done", host_done, 1'b0);
		cpu_read(io_addr(8'd7), got);
		check_byte("tmr1", got, 8'h00);
		cpu_read(io_addr(8'd8), got);
		check_byte("tmr2", got, 8'h00);

		// Random zero page, then unmapped space
		repeat (64) zp_traffic();
		foreach (zp_valid[i]) begin
			if (zp_valid[i])
				cpu_read(addr_t'(i), got);
		end
		cpu_read(io_addr(8'd3), got);
		cpu_read(io_addr(8'd5), got);
		cpu_read(io_addr(8'd9), got);
		cpu_read(io_addr(8'hFF), got);
		cpu_read(16'h8000, got);

		// Host writes delayed by processor traffic
		for (int i = 0; i < fdc_io_pkg::HOST_REGS; i++) begin
			r = next_rand();
			host_write(i, r[7:0]);
			repeat (i + 1) zp_traffic();
			wait_done(host_ops);
		end
		for (int i = 0; i < fdc_io_pkg::HOST_REGS; i++)
			cpu_read(mbox_addr(i), got);

		// Processor fills the mailbox, host reads back
		for (int i = 0; i < fdc_io_pkg::HOST_REGS; i++) begin
			r = next_rand();
			cpu_write(mbox_addr(i), r[15:8]);
			host_read(i, got);
			check_byte("hostio_odata", got, r[15:8]);
		end

		// LED and chip-select latches
		r = next_rand();
		cpu_write(io_addr(8'd16), r[7:0]);
		check_byte("leds", leds, r[7:0]);
		cpu_write(io_addr(8'd0), 8'h00);
		check_bit("sd_cs", sd_cs, 1'b0);

		// SPI byte exchange
		r = next_rand();
		d = r[7:0];
		spi_tx = r[15:8];
		spi_arm = 1'b1;
		repeat (2) @(negedge clk);
		cpu_write(io_addr(8'd1), d);
		cpu_read(io_addr(8'd2), got);
		check_bit("spsr_ready", got[fdc_io_pkg::ST_BUSY_BIT], 1'b0);
		n = 0;
		while (!got[fdc_io_pkg::ST_BUSY_BIT] && n < POLL_MAX) begin
			cpu_read(io_addr(8'd2), got);
			n++;
		end
		if (!got[fdc_io_pkg::ST_BUSY_BIT])
			fail_note("timeout waiting for SPI ready");
		if (spi_bits != 8)
			fail_note("SPI transfer did not give eight clocks");
		check_byte("sd_mosi", spi_rx, d);
		spdr_exp = spi_tx;
		cpu_read(io_addr(8'd1), got);
		cpu_write(io_addr(8'd0), 8'h01);
		check_bit("sd_cs", sd_cs, 1'b1);

		// UART frame, second write lands while busy
		r = next_rand();
		d = r[7:0];
		frames = uart_frames;
		cpu_write(io_addr(8'd4), d);
		cpu_write(io_addr(8'd4), ~d);
		cpu_read(io_addr(8'd6), got);
		check_bit("ctl_busy", got[fdc_io_pkg::ST_BUSY_BIT], 1'b1);
		n = 0;
		while (got[fdc_io_pkg::ST_BUSY_BIT] && n < POLL_MAX) begin
			cpu_read(io_addr(8'd6), got);
			n++;
		end
		if (got[fdc_io_pkg::ST_BUSY_BIT])
			fail_note("timeout waiting for UART busy to clear");
		// Busy covers the whole frame, stop bit included
		if (uart_frames == frames)
			fail_note("UART busy cleared before the frame ended");
		check_byte("uart_txd", uart_rx, d);
		repeat (4 * BAUD_DIV) @(negedge clk);
		if (uart_frames != frames + 1)
			fail_note("UART sent a frame for a write made while busy");
		check_bit("uart_txd", uart_txd, 1'b1);

		// Both timers run down to zero
		timer_run(8'd7, 8'd6);
		timer_run(8'd8, 8'd3);

		repeat (4) @(negedge clk);
		if (want_q.size() != 0)
			fail_note("expected reads left unchecked");
		// One done pulse per host access
		if (done_cnt != host_ops)
			fail_note("host_done count differs from the number of host accesses");
		$display("Checks done: %0d value errors, %0d other errors", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/fdc_bus_pkg.sv
hdl/fdc_io_pkg.sv
hdl/fdc_bus_if.sv
hdl/fdc_uart_tx.sv
hdl/fdc_spi_master.sv
hdl/fdc_zero_page.sv
hdl/fdc_io_ports.sv
hdl/fdc_bus_arbiter.sv
hdl/fdc_subsystem.sv
verif/fdc_props.sv
verif/fdc_tb.sv

// ==== Makefile ====
# Verilator build and run of the floppy controller I/O subsystem

TOP = fdc_tb

all: run

obj_dir/V$(TOP): flist.f $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
